// ==== common/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Width of every PC in the fetch path.
`define FETCH_PC_W 64

// Instruction memory word address width, so the memory holds 2**IMEM_AW words.
`define IMEM_AW 10

// First fetch address after reset. It must lie inside the instruction memory.
`define FETCH_RESET_PC 64'h0000_0000_0000_0040

`endif

// ==== common/fetch_types_pkg.sv ====
`include "fetch_params.svh"

package fetch_types_pkg;

  // Why a word or an instruction was fetched.
  // The low bit marks the first fetch at a new target, and the aligner tests that bit directly.
  typedef enum logic [1:0] {
    IF_PREFETCH = 2'b00,
    IF_REDIRECT = 2'b01
  } if_reason_e;

  // Exception causes, numbered as in the RISC-V mcause register.
  // Only the access fault is raised by this front end.
  typedef enum logic [3:0] {
    EXC_INSTR_MISALIGNED   = 4'd0,
    EXC_INSTR_ACCESS_FAULT = 4'd1
  } exc_cause_e;

  // One whole instruction as it leaves the aligner.
  // For a 16-bit instruction the upper half of instr_word is zero.
  // An exception record carries the PC of the first half-word it could not fetch.
  typedef struct packed {
    logic [`FETCH_PC_W-1:0] pc;
    logic [31:0]            instr_word;
    if_reason_e             if_reason;
    logic                   ex_valid;
    exc_cause_e             ex_cause;
  } fetched_instr_t;

endpackage

// ==== common/rv_instr_pkg.sv ====
package rv_instr_pkg;

  import fetch_types_pkg::*;

  // Coarse instruction class, enough for the backend to route an instruction.
  typedef enum logic [2:0] {
    OP_ALU    = 3'd0,
    OP_LOAD   = 3'd1,
    OP_STORE  = 3'd2,
    OP_BRANCH = 3'd3,
    OP_JAL    = 3'd4,
    OP_JALR   = 3'd5,
    OP_SYSTEM = 3'd6,
    OP_OTHER  = 3'd7
  } op_class_e;

  // A fetched instruction together with its predecode result.
  typedef struct packed {
    fetched_instr_t instr;
    logic           compressed;
    op_class_e      op_class;
  } predecoded_t;

endpackage

// ==== common/fetch_word_if.sv ====
`timescale 1ns/10ps
`include "fetch_params.svh"

// One fetched memory word on its way to the aligner.
// A word moves on a cycle where valid and ready are both high.
interface fetch_word_if;

  import fetch_types_pkg::*;

  logic                   valid;
  logic                   ready;
  // Word aligned, except for a redirect target at the upper half-word.
  logic [`FETCH_PC_W-1:0] pc;
  logic                   exception;
  exc_cause_e             ex_code;
  if_reason_e             reason;
  // One bit per half-word, bit 0 for the lower half.
  logic [1:0]             strb;
  logic [31:0]            instr;

  modport source (
    output valid, pc, exception, ex_code, reason, strb, instr,
    input  ready
  );

  modport sink (
    input  valid, pc, exception, ex_code, reason, strb, instr,
    output ready
  );

endinterface

// ==== verilog/fetch_word_gen.sv ====
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_word_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   redirect_valid_i,
  input  logic [`FETCH_PC_W-1:0] redirect_pc_i,
  output logic                   imem_req_o,
  output logic [`IMEM_AW-1:0]    imem_addr_o,
  input  logic [31:0]            imem_rdata_i,
  input  logic                   imem_err_i,
  fetch_word_if.source           word_o
);

  import fetch_types_pkg::*;

  // FLUSH means the next request is the first one at a new target.
  // HALT is entered once a faulting word has been handed on.
  typedef enum logic [1:0] {
    RUN,
    HALT,
    FLUSH
  } gen_state_e;

  gen_state_e             state_q, state_d;
  logic [`FETCH_PC_W-1:0] fetch_pc_q, fetch_pc_d;
  logic [`FETCH_PC_W-1:0] resp_pc_q;
  if_reason_e             resp_reason_q;
  logic                   pend_q;
  logic                   hold_valid_q;
  logic [31:0]            hold_rdata_q;
  logic                   hold_err_q;
  logic                   fault_xfer;

  // The presented word comes from the holding register when it is full, else straight from
  // the memory response. A redirect drops whatever is on offer.
  assign word_o.valid     = (pend_q || hold_valid_q) && !redirect_valid_i;
  assign word_o.pc        = resp_pc_q;
  assign word_o.reason    = resp_reason_q;
  assign word_o.strb      = resp_pc_q[1] ? 2'b10 : 2'b11;
  assign word_o.instr     = hold_valid_q ? hold_rdata_q : imem_rdata_i;
  assign word_o.exception = hold_valid_q ? hold_err_q : imem_err_i;
  assign word_o.ex_code   = EXC_INSTR_ACCESS_FAULT;

  assign fault_xfer = word_o.valid && word_o.ready && word_o.exception;

  // A request is only made when the word slot is free next cycle.
  // Nothing is fetched behind a faulting word, so no stale response can follow it.
  assign imem_req_o  = state_q != HALT && !redirect_valid_i &&
                       !(word_o.valid && (word_o.exception || !word_o.ready));
  assign imem_addr_o = fetch_pc_q[`IMEM_AW+1:2];

  always_comb begin
    state_d    = state_q;
    fetch_pc_d = fetch_pc_q;
    if (redirect_valid_i) begin
      state_d    = FLUSH;
      fetch_pc_d = redirect_pc_i;
    end else if (fault_xfer) begin
      state_d = HALT;
    end else if (imem_req_o) begin
      // Fetch continues at the next aligned word, also after an odd half-word target.
      state_d    = RUN;
      fetch_pc_d = {fetch_pc_q[`FETCH_PC_W-1:2] + 1'b1, 2'b00};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FLUSH;
      fetch_pc_q   <= `FETCH_RESET_PC;
      pend_q       <= 1'b0;
      hold_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      fetch_pc_q   <= fetch_pc_d;
      pend_q       <= imem_req_o;
      hold_valid_q <= word_o.valid && !word_o.ready;
    end
  end

  // The PC and reason of a request stay put until its word is taken, since no request
  // is made while a word stalls.
  always_ff @(posedge clk_i) begin
    if (imem_req_o) begin
      resp_pc_q     <= fetch_pc_q;
      resp_reason_q <= state_q == FLUSH ? IF_REDIRECT : IF_PREFETCH;
    end
    if (!hold_valid_q) begin
      hold_rdata_q <= imem_rdata_i;
      hold_err_q   <= imem_err_i;
    end
  end

  // A full holding register never meets a response in flight, since no request is made
  // while a word stalls.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    hold_valid_q |-> !pend_q);

endmodule

// ==== instr_align/instr_align.sv ====
`timescale 1ns/10ps
`include "fetch_params.svh"

module instr_align (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  fetch_word_if.sink                      word_i,
  output logic                            aligned_valid_o,
  input  logic                            aligned_ready_i,
  output fetch_types_pkg::fetched_instr_t aligned_instr_o
);

  import fetch_types_pkg::*;

  // The window is three half-words: the carried half-word at index 0 and the input word at
  // indexes 1 and 2. Index 3 is a zero pad so that a length probe never reads past the end.
  // Buffer indexes are 0 or 1, and start equal to end means the buffer is empty.
  logic [15:0]            buf_q, buf_d;
  logic                   buf_start_q, buf_start_d;
  logic                   buf_end_q, buf_end_d;
  // PC of the word that follows the buffer, which is the window PC whenever the buffer is used.
  logic [`FETCH_PC_W-1:0] buf_pc_q, buf_pc_d;
  if_reason_e             buf_reason_q, buf_reason_d;

  logic                   buf_empty;
  logic                   buf_instr_empty;
  logic                   buf_instr_full;
  logic [1:0]             in_start_idx;
  logic [1:0]             in_end_idx;
  logic [`FETCH_PC_W-1:0] in_pc;
  logic                   use_buffer;
  logic                   use_input;

  logic [3:0][15:0]       win_instr;
  logic [1:0]             win_start_idx;
  logic [1:0]             win_end_idx;
  logic [1:0]             next_idx;
  logic [1:0]             instr_len;
  logic [`FETCH_PC_W-1:0] win_pc;
  logic [`FETCH_PC_W-1:0] instr_pc;
  logic                   win_exception;
  if_reason_e             win_reason;

  assign buf_empty = buf_start_q == buf_end_q;
  // A lone upper half of a 32-bit instruction cannot be emitted without more input.
  assign buf_instr_empty = buf_empty || buf_q[1:0] == 2'b11;
  // A whole 16-bit instruction in the buffer must leave before more input is taken.
  assign buf_instr_full = !buf_empty && buf_q[1:0] != 2'b11;

  assign in_start_idx = word_i.strb[0] ? 2'd0 : 2'd1;
  assign in_end_idx   = word_i.strb[1] ? 2'd2 : 2'd1;
  assign in_pc        = {word_i.pc[`FETCH_PC_W-1:2], 2'b00};

  always_comb begin
    if (word_i.valid && word_i.reason[0]) begin
      // New target, so the buffer content is stale.
      use_buffer = 1'b0;
      use_input  = 1'b1;
    end else if (word_i.valid && !word_i.exception) begin
      // Sequential data continues the buffer.
      use_buffer = 1'b1;
      use_input  = !buf_instr_full;
    end else if (!buf_instr_empty) begin
      // Ahead of a fault, whole instructions still in the buffer go out first.
      use_buffer = 1'b1;
      use_input  = 1'b0;
    end else if (word_i.valid) begin
      // Fault word; the buffer is kept so that the record points at the start of a split
      // instruction.
      use_buffer = 1'b1;
      use_input  = 1'b1;
    end else begin
      use_buffer = 1'b1;
      use_input  = 1'b0;
    end
  end

  assign win_instr = {16'h0000, word_i.instr, buf_q};

  always_comb begin
    win_start_idx = use_buffer ? {1'b0, buf_start_q} : in_start_idx + 2'd1;
    win_end_idx   = use_input ? in_end_idx + 2'd1 : {1'b0, buf_end_q};
    win_pc        = use_input ? in_pc : buf_pc_q;
    win_exception = use_input && word_i.exception;
    if (use_buffer && !buf_empty) begin
      win_reason = buf_reason_q;
    end else begin
      win_reason = word_i.reason;
    end
  end

  // Length in half-words of the instruction at the window start, zero if it is incomplete.
  always_comb begin
    if (win_start_idx == win_end_idx) begin
      instr_len = 2'd0;
    end else if (win_instr[win_start_idx][1:0] != 2'b11) begin
      instr_len = 2'd1;
    end else if (win_end_idx == win_start_idx + 2'd1) begin
      instr_len = 2'd0;
    end else begin
      instr_len = 2'd2;
    end
  end

  assign next_idx = win_start_idx + instr_len;
  // Index 1 sits at the window PC, so index 0 lies one half-word before it.
  assign instr_pc = win_pc + {win_start_idx, 1'b0} - 2'd2;

  always_comb begin
    buf_d        = buf_q;
    buf_start_d  = buf_start_q;
    buf_end_d    = buf_end_q;
    buf_pc_d     = buf_pc_q;
    buf_reason_d = buf_reason_q;
    word_i.ready = 1'b0;

    aligned_instr_o           = '0;
    aligned_instr_o.pc        = instr_pc;
    aligned_instr_o.if_reason = win_reason;

    if (win_exception) begin
      // One fault record, after which the buffer is empty.
      aligned_valid_o          = 1'b1;
      aligned_instr_o.ex_valid = 1'b1;
      aligned_instr_o.ex_cause = word_i.ex_code;
      if (aligned_ready_i) begin
        buf_start_d  = 1'b1;
        buf_end_d    = 1'b1;
        word_i.ready = 1'b1;
      end
    end else begin
      aligned_valid_o            = instr_len != 2'd0;
      aligned_instr_o.instr_word = {instr_len == 2'd2 ? win_instr[win_start_idx + 2'd1] : 16'h0000,
                                    win_instr[win_start_idx]};
      if (instr_len == 2'd0 || aligned_ready_i) begin
        // Whatever is left behind an emitted instruction is sequential.
        buf_reason_d = instr_len != 2'd0 ? IF_PREFETCH : win_reason;
        if (use_input) begin
          // The upper input half-word becomes the buffer; index 2 or 3 maps to 0 or 1.
          buf_d        = win_instr[2];
          buf_start_d  = next_idx == 2'd3;
          buf_end_d    = in_end_idx[1];
          buf_pc_d     = in_pc + 3'd4;
          word_i.ready = 1'b1;
        end else begin
          buf_start_d = next_idx[0];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_start_q <= 1'b1;
      buf_end_q   <= 1'b1;
    end else if (flush_i) begin
      buf_start_q <= 1'b1;
      buf_end_q   <= 1'b1;
    end else begin
      buf_start_q <= buf_start_d;
      buf_end_q   <= buf_end_d;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q        <= buf_d;
    buf_pc_q     <= buf_pc_d;
    buf_reason_q <= buf_reason_d;
  end

  // A stalled instruction stays on offer unchanged, which relies on the word source holding
  // its word while ready is low.
  assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    aligned_valid_o && !aligned_ready_i |=> aligned_valid_o && $stable(aligned_instr_o));

endmodule

// ==== verilog/instr_predecode.sv ====
`timescale 1ns/10ps

module instr_predecode (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  input  fetch_types_pkg::fetched_instr_t in_instr_i,
  output logic                            out_valid_o,
  input  logic                            out_ready_i,
  output rv_instr_pkg::predecoded_t       out_rec_o
);

  import rv_instr_pkg::*;

  logic [31:0] word;
  logic        compressed;
  op_class_e   op_class;
  logic        out_valid_q;
  predecoded_t rec_q;

  assign word = in_instr_i.instr_word;
  // A fault record holds no instruction, so it is neither compressed nor classified.
  assign compressed = !in_instr_i.ex_valid && word[1:0] != 2'b11;

  always_comb begin
    op_class = OP_OTHER;
    if (in_instr_i.ex_valid) begin
      op_class = OP_OTHER;
    end else if (!compressed) begin
      // Major opcode; OP, OP-IMM, LUI, AUIPC and their 32-bit forms all count as ALU.
      case (word[6:0])
        7'b0110011, 7'b0010011, 7'b0110111,
        7'b0010111, 7'b0111011, 7'b0011011: op_class = OP_ALU;
        7'b0000011: op_class = OP_LOAD;
        7'b0100011: op_class = OP_STORE;
        7'b1100011: op_class = OP_BRANCH;
        7'b1101111: op_class = OP_JAL;
        7'b1100111: op_class = OP_JALR;
        7'b1110011: op_class = OP_SYSTEM;
        default:    op_class = OP_OTHER;
      endcase
    end else begin
      // Compressed forms by quadrant and funct3.
      case ({word[1:0], word[15:13]})
        5'b00_000: op_class = OP_ALU;
        5'b00_001, 5'b00_010, 5'b00_011: op_class = OP_LOAD;
        5'b00_101, 5'b00_110, 5'b00_111: op_class = OP_STORE;
        5'b01_000, 5'b01_001, 5'b01_010,
        5'b01_011, 5'b01_100: op_class = OP_ALU;
        5'b01_101: op_class = OP_JAL;
        5'b01_110, 5'b01_111: op_class = OP_BRANCH;
        5'b10_000: op_class = OP_ALU;
        5'b10_001, 5'b10_010, 5'b10_011: op_class = OP_LOAD;
        5'b10_100: begin
          // c.mv and c.add name rs2; with rs2 zero it is c.jr, c.jalr or c.ebreak.
          if (word[6:2] != 5'd0) begin
            op_class = OP_ALU;
          end else if (word[11:7] != 5'd0) begin
            op_class = OP_JALR;
          end else if (word[12]) begin
            op_class = OP_SYSTEM;
          end else begin
            op_class = OP_OTHER;
          end
        end
        5'b10_101, 5'b10_110, 5'b10_111: op_class = OP_STORE;
        default: op_class = OP_OTHER;
      endcase
    end
  end

  // The slice takes a new record in the same cycle that its held one drains.
  assign in_ready_o = !out_valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (flush_i) begin
      out_valid_q <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      rec_q.instr      <= in_instr_i;
      rec_q.compressed <= compressed;
      rec_q.op_class   <= op_class;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_rec_o   = rec_q;

endmodule

// ==== verilog/fetch_front_top.sv ====
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_front_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  output logic                        imem_req_o,
  output logic [`IMEM_AW-1:0]         imem_addr_o,
  input  logic [31:0]                 imem_rdata_i,
  input  logic                        imem_err_i,
  input  logic                        redirect_valid_i,
  input  logic [`FETCH_PC_W-1:0]      redirect_pc_i,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic [`FETCH_PC_W-1:0]      out_pc_o,
  output logic [31:0]                 out_instr_o,
  output logic                        out_compressed_o,
  output rv_instr_pkg::op_class_e     out_class_o,
  output fetch_types_pkg::if_reason_e out_reason_o,
  output logic                        out_ex_valid_o,
  output fetch_types_pkg::exc_cause_e out_ex_cause_o
);

  import fetch_types_pkg::*;
  import rv_instr_pkg::*;

  fetch_word_if   word_if ();
  logic           aligned_valid;
  logic           aligned_ready;
  fetched_instr_t aligned_instr;
  predecoded_t    out_rec;

  // The redirect pulse flushes every stage in the same cycle.
  fetch_word_gen u_word_gen (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .imem_req_o       (imem_req_o),
    .imem_addr_o      (imem_addr_o),
    .imem_rdata_i     (imem_rdata_i),
    .imem_err_i       (imem_err_i),
    .word_o           (word_if.source)
  );

  instr_align u_align (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (redirect_valid_i),
    .word_i          (word_if.sink),
    .aligned_valid_o (aligned_valid),
    .aligned_ready_i (aligned_ready),
    .aligned_instr_o (aligned_instr)
  );

  instr_predecode u_predecode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (redirect_valid_i),
    .in_valid_i  (aligned_valid),
    .in_ready_o  (aligned_ready),
    .in_instr_i  (aligned_instr),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_rec_o   (out_rec)
  );

  assign out_pc_o         = out_rec.instr.pc;
  assign out_instr_o      = out_rec.instr.instr_word;
  assign out_compressed_o = out_rec.compressed;
  assign out_class_o      = out_rec.op_class;
  assign out_reason_o     = out_rec.instr.if_reason;
  assign out_ex_valid_o   = out_rec.instr.ex_valid;
  assign out_ex_cause_o   = out_rec.instr.ex_cause;

endmodule

// ==== verif/fetch_front_tb.sv ====
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_front_tb;

  import fetch_types_pkg::*;
  import rv_instr_pkg::*;

  // Instruction counts per test. The fault test can see at most 32 half-words before the
  // error region plus the fault record itself.
  localparam int n_seq      = 40;
  localparam int n_odd      = 10;
  localparam int n_rand     = 60;
  localparam int n_fault    = 33;
  localparam int n_resume   = 30;
  localparam int max_cycles = (n_seq + n_odd + n_rand + n_fault + n_resume) * 8 + 200;

  // Word addresses that answer with a memory error, bytes 0x600 to 0x61f.
  localparam logic [`IMEM_AW-1:0] err_lo = 'h180;
  localparam logic [`IMEM_AW-1:0] err_hi = 'h187;

  typedef struct packed {
    logic [`FETCH_PC_W-1:0] pc;
    logic [1:0]             len;
    logic [31:0]            word;
    logic                   compressed;
    op_class_e              op_class;
    if_reason_e             reason;
    logic                   ex_valid;
  } exp_rec_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   imem_req_o;
  logic [`IMEM_AW-1:0]    imem_addr_o;
  logic [31:0]            imem_rdata_i;
  logic                   imem_err_i;
  logic                   redirect_valid_i;
  logic [`FETCH_PC_W-1:0] redirect_pc_i;
  logic                   out_valid_o;
  logic                   out_ready_i;
  logic [`FETCH_PC_W-1:0] out_pc_o;
  logic [31:0]            out_instr_o;
  logic                   out_compressed_o;
  op_class_e              out_class_o;
  if_reason_e             out_reason_o;
  logic                   out_ex_valid_o;
  exc_cause_e             out_ex_cause_o;

  // Memory contents as half-words, indexed by byte address bits [IMEM_AW:1].
  logic [15:0]            mem_h [0:2**(`IMEM_AW+1)-1];
  integer                 seed = 32'h1d68b52a;
  logic                   req_q = 1'b0;
  logic [`IMEM_AW-1:0]    addr_q = '0;
  logic                   rand_ready;
  string                  test_name;
  int                     err_cnt = 0;
  int                     check_cnt = 0;
  int                     cycle_cnt = 0;
  logic                   fault_seen;

  // Checker state. A pending redirect takes effect at the first IF_REDIRECT output.
  exp_rec_t               exp_rec;
  logic [`FETCH_PC_W-1:0] exp_pc;
  logic                   exp_first;
  logic                   halted;
  logic                   pend_redirect;
  logic [`FETCH_PC_W-1:0] pend_pc;

  fetch_front_top dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .imem_req_o       (imem_req_o),
    .imem_addr_o      (imem_addr_o),
    .imem_rdata_i     (imem_rdata_i),
    .imem_err_i       (imem_err_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .out_pc_o         (out_pc_o),
    .out_instr_o      (out_instr_o),
    .out_compressed_o (out_compressed_o),
    .out_class_o      (out_class_o),
    .out_reason_o     (out_reason_o),
    .out_ex_valid_o   (out_ex_valid_o),
    .out_ex_cause_o   (out_ex_cause_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic in_err_region(input logic [`IMEM_AW-1:0] waddr);
    return waddr >= err_lo && waddr <= err_hi;
  endfunction

  // Class of one instruction. 32-bit forms go by the major opcode in bits [6:2].
  function automatic op_class_e classify_instr(input logic [31:0] w);
    op_class_e c;
    c = OP_OTHER;
    if (w[1:0] == 2'b11) begin
      case (w[6:2])
        5'b01100, 5'b00100, 5'b01101, 5'b00101, 5'b01110, 5'b00110: c = OP_ALU;
        5'b00000: c = OP_LOAD;
        5'b01000: c = OP_STORE;
        5'b11000: c = OP_BRANCH;
        5'b11011: c = OP_JAL;
        5'b11001: c = OP_JALR;
        5'b11100: c = OP_SYSTEM;
        default:  c = OP_OTHER;
      endcase
    end else if (w[1:0] == 2'b00) begin
      // Quadrant 0 holds c.addi4spn, loads, one reserved slot and stores.
      case (w[15:13])
        3'b000:  c = OP_ALU;
        3'b100:  c = OP_OTHER;
        default: c = w[15] ? OP_STORE : OP_LOAD;
      endcase
    end else if (w[1:0] == 2'b01) begin
      case (w[15:13])
        3'b101:         c = OP_JAL;
        3'b110, 3'b111: c = OP_BRANCH;
        default:        c = OP_ALU;
      endcase
    end else begin
      case (w[15:13])
        3'b000: c = OP_ALU;
        3'b100: begin
          // With rs2 zero this slot is c.jr, c.jalr or c.ebreak, else c.mv or c.add.
          if (w[6:2] != 5'd0) begin
            c = OP_ALU;
          end else if (w[11:7] != 5'd0) begin
            c = OP_JALR;
          end else begin
            c = w[12] ? OP_SYSTEM : OP_OTHER;
          end
        end
        default: c = w[15] ? OP_STORE : OP_LOAD;
      endcase
    end
    return c;
  endfunction

  // Expected record for the instruction that starts at pc.
  function automatic exp_rec_t expected_instr(input logic [`FETCH_PC_W-1:0] pc,
                                              input logic first);
    exp_rec_t               r;
    logic [`IMEM_AW:0]      hidx;
    logic [`FETCH_PC_W-1:0] pc_hi;
    logic [15:0]            lo;
    logic [15:0]            hi;
    hidx  = pc[`IMEM_AW:1];
    pc_hi = pc + 64'd2;
    lo    = mem_h[hidx];
    hi    = mem_h[hidx + 1'b1];
    r        = '0;
    r.pc     = pc;
    r.reason = first ? IF_REDIRECT : IF_PREFETCH;
    r.len    = lo[1:0] == 2'b11 ? 2'd2 : 2'd1;
    if (in_err_region(pc[`IMEM_AW+1:2]) ||
        (r.len == 2'd2 && in_err_region(pc_hi[`IMEM_AW+1:2]))) begin
      r.ex_valid = 1'b1;
      r.op_class = OP_OTHER;
    end else begin
      r.word       = r.len == 2'd2 ? {hi, lo} : {16'h0000, lo};
      r.compressed = r.len == 2'd1;
      r.op_class   = classify_instr(r.word);
    end
    return r;
  endfunction

  task automatic check_field(input string field, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    assert (exp_v === act_v) else begin
      err_cnt++;
      $display("Fail %s %s at pc %h: expected %h, actual %h",
               test_name, field, out_pc_o, exp_v, act_v);
    end
  endtask

  task automatic place_half(input logic [`FETCH_PC_W-1:0] addr, input logic [15:0] h);
    mem_h[addr[`IMEM_AW:1]] = h;
  endtask

  task automatic place_word(input logic [`FETCH_PC_W-1:0] addr, input logic [31:0] w);
    place_half(addr, w[15:0]);
    place_half(addr + 64'd2, w[31:16]);
  endtask

  // One instruction of every class in both lengths, starting at the reset PC.
  // Several 32-bit ones sit at odd half-words and so cross a word boundary.
  task automatic place_classes();
    place_half(64'h40, 16'h0505);
    place_word(64'h42, 32'h00b50533);
    place_half(64'h46, 16'h4188);
    place_word(64'h48, 32'h0005a503);
    place_half(64'h4c, 16'hc188);
    place_word(64'h4e, 32'h00a5a023);
    place_half(64'h52, 16'hc101);
    place_word(64'h54, 32'h00b50463);
    place_half(64'h58, 16'ha001);
    place_word(64'h5a, 32'h008000ef);
    place_half(64'h5e, 16'h8082);
    place_half(64'h60, 16'h9582);
    place_word(64'h62, 32'h000500e7);
    place_half(64'h66, 16'h9002);
    place_word(64'h68, 32'h00000073);
    place_half(64'h6c, 16'h852e);
    place_word(64'h6e, 32'h0000000f);
    place_half(64'h72, 16'h8000);
    place_half(64'h74, 16'h4502);
    place_half(64'h76, 16'hc02a);
    place_word(64'h78, 32'h000125b7);
    place_half(64'h7c, 16'h0040);
  endtask

  task automatic issue_redirect(input logic [`FETCH_PC_W-1:0] pc);
    @(negedge clk_i);
    redirect_valid_i = 1'b1;
    redirect_pc_i    = pc;
    @(negedge clk_i);
    redirect_valid_i = 1'b0;
  endtask

  task automatic wait_checks(input int n);
    int target;
    target = check_cnt + n;
    while (check_cnt < target) begin
      @(negedge clk_i);
    end
  endtask

  // The memory registers each request and answers in the next cycle.
  always @(posedge clk_i) begin
    req_q  <= imem_req_o;
    addr_q <= imem_addr_o;
  end

  always @(negedge clk_i) begin
    if (req_q) begin
      imem_rdata_i = {mem_h[{addr_q, 1'b1}], mem_h[{addr_q, 1'b0}]};
      imem_err_i   = in_err_region(addr_q);
    end else begin
      imem_rdata_i = '0;
      imem_err_i   = 1'b0;
    end
    out_ready_i = rand_ready ? $random(seed) : 1'b1;
  end

  // Every output transfer is checked against the next record of the reference stream.
  always @(posedge clk_i) begin
    if (rst_ni && out_valid_o && out_ready_i) begin
      if (pend_redirect && out_reason_o == IF_REDIRECT) begin
        exp_pc        = pend_pc;
        exp_first     = 1'b1;
        pend_redirect = 1'b0;
        halted        = 1'b0;
      end
      assert (!halted) else begin
        err_cnt++;
        $display("Error in %s: an instruction at pc %h came out after an access fault",
                 test_name, out_pc_o);
      end
      if (!halted) begin
        exp_rec = expected_instr(exp_pc, exp_first);
        check_field("pc", exp_rec.pc, out_pc_o);
        check_field("reason", exp_rec.reason, out_reason_o);
        check_field("ex_valid", exp_rec.ex_valid, out_ex_valid_o);
        check_field("class", exp_rec.op_class, out_class_o);
        if (exp_rec.ex_valid) begin
          check_field("ex_cause", EXC_INSTR_ACCESS_FAULT, out_ex_cause_o);
          halted     = 1'b1;
          fault_seen = 1'b1;
        end else begin
          check_field("instr", exp_rec.word, out_instr_o);
          check_field("compressed", exp_rec.compressed, out_compressed_o);
        end
        exp_pc    = exp_pc + {exp_rec.len, 1'b0};
        exp_first = 1'b0;
      end
      check_cnt++;
    end
    if (rst_ni && redirect_valid_i) begin
      pend_redirect = 1'b1;
      pend_pc       = redirect_pc_i;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      $display("Timeout: only %0d instructions came out within %0d cycles",
               check_cnt, max_cycles);
      $display("Checks: %0d, errors: %0d", check_cnt, err_cnt + 1);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    rst_ni           = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    out_ready_i      = 1'b0;
    imem_rdata_i     = '0;
    imem_err_i       = 1'b0;
    rand_ready       = 1'b0;
    fault_seen       = 1'b0;
    halted           = 1'b0;
    exp_pc           = '0;
    exp_first        = 1'b0;
    // The first fetch after reset counts as a redirect to the reset PC.
    pend_redirect    = 1'b1;
    pend_pc          = `FETCH_RESET_PC;
    test_name        = "reset_stream";
    for (int i = 0; i < 2**(`IMEM_AW+1); i++) begin
      mem_h[i] = $random(seed);
    end
    place_classes();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    wait_checks(n_seq);

    test_name = "odd_redirect";
    issue_redirect(64'h202);
    wait_checks(n_odd);

    test_name  = "random_ready";
    rand_ready = 1'b1;
    wait_checks(n_rand);

    // Fetch runs into the error region, then must stay quiet until the next redirect.
    test_name = "access_fault";
    issue_redirect(64'h5c0);
    while (!fault_seen) begin
      @(negedge clk_i);
    end
    repeat (30) @(negedge clk_i);

    test_name = "resume";
    issue_redirect(64'h100);
    wait_checks(n_resume);

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== fetch_front.f ====
+incdir+common
common/fetch_types_pkg.sv
common/rv_instr_pkg.sv
common/fetch_word_if.sv
verilog/fetch_word_gen.sv
instr_align/instr_align.sv
verilog/instr_predecode.sv
verilog/fetch_front_top.sv
verif/fetch_front_tb.sv
